// ==== dv/memSubsys_vectors.txt ====
# op addr len wdata expected (hex, len decimal); S store, L load, F fetch, B load+fetch together
# X rows: addr 1 turns random io-full windows on, 0 turns them off
S 00100 4 11223344 00000000
L 00100 4 00000000 11223344
L 00100 1 00000000 00000044
L 00100 2 00000000 00003344
S 00101 1 000000aa 00000000
L 00100 4 00000000 1122aa44
S 00102 2 0000beef 00000000
L 00100 4 00000000 beefaa44
L 00102 2 00000000 0000beef
L 00101 1 00000000 000000aa
S 00200 4 00c58593 00000000
F 00200 4 00000000 00c58593
S 00204 4 fe010113 00000000
F 00204 4 00000000 fe010113
F 00202 4 00000000 011300c5
S 1fffc 4 deadbeef 00000000
L 1fffc 4 00000000 deadbeef
F 1fffc 4 00000000 deadbeef
L 1fffe 2 00000000 0000dead
L 1ffff 1 00000000 000000de
B 00100 4 00000000 beefaa44
B 00200 4 00000000 00c58593
X 00001 0 00000000 00000000
S 00300 4 a5a5f00f 00000000
L 00300 4 00000000 a5a5f00f
S 00303 1 0000003c 00000000
L 00300 4 00000000 3ca5f00f
L 00300 2 00000000 0000f00f
F 00300 4 00000000 3ca5f00f
S 00400 2 00001234 00000000
L 00400 2 00000000 00001234
L 00401 1 00000000 00000012
B 00204 4 00000000 fe010113
F 00100 4 00000000 beefaa44
L 00102 2 00000000 0000beef
S 00100 4 cafef00d 00000000
B 00100 4 00000000 cafef00d
X 00000 0 00000000 00000000
L 00300 4 00000000 3ca5f00f
F 00204 4 00000000 fe010113

// ==== sim.f ====
+incdir+rtl
rtl/memctrl_pkg.sv
rtl/memReqIf.sv
rtl/reqArbiter.sv
rtl/byteSequencer.sv
rtl/byteRam.sv
rtl/memSubsys.sv
dv/memSubsys_tb.sv

// ==== Bender.yml ====
package:
  name: memsubsys

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/memctrl_pkg.sv
      - rtl/memReqIf.sv
      - rtl/reqArbiter.sv
      - rtl/byteSequencer.sv
      - rtl/byteRam.sv
      - rtl/memSubsys.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/memSubsys_tb.sv

// ==== dv/memSubsys_tb.sv ====
`include "memctrl_config.svh"

module memSubsys_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import memctrl_pkg::*;

    localparam int ACK_TIMEOUT = 200;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  i_ioFull;
    logic                  i_fetchReq;
    logic [`MC_ADDR_W-1:0] i_fetchAddr;
    logic                  o_fetchAck;
    logic [`MC_DATA_W-1:0] o_fetchInst;
    logic                  i_dataReq;
    logic                  i_dataWrite;
    logic [LEN_W-1:0]      i_dataLen;
    logic [`MC_ADDR_W-1:0] i_dataAddr;
    logic [`MC_DATA_W-1:0] i_dataWdata;
    logic                  o_dataAck;
    logic [`MC_DATA_W-1:0] o_dataRdata;

    integer      seed = 32'h152;
    logic [31:0] rnd;
    logic [1:0]  gapDraw = 2'd0;
    int          stallLeft = 0;
    logic        stallOn = 1'b0;
    memOp_e      firstAck;
    int          errCount = 0;
    int          timeoutCount = 0;
    int          fileErrCount = 0;
    int          quietCycles = 0;
    logic        dataAckPrev = 1'b0;
    logic        fetchAckPrev = 1'b0;

    memSubsys u_memSubsys (
        .clk         (clk),
        .rst         (rst),
        .i_ioFull    (i_ioFull),
        .i_fetchReq  (i_fetchReq),
        .i_fetchAddr (i_fetchAddr),
        .o_fetchAck  (o_fetchAck),
        .o_fetchInst (o_fetchInst),
        .i_dataReq   (i_dataReq),
        .i_dataWrite (i_dataWrite),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .o_dataAck   (o_dataAck),
        .o_dataRdata (o_dataRdata)
    );

    always #50 clk = ~clk;

    // io-full windows and requester gaps drawn once per cycle
    always @(posedge clk) begin
        rnd = $random(seed);
        gapDraw <= rnd[17:16];
        if (rst || !stallOn) begin
            i_ioFull <= 1'b0;
            stallLeft = 0;
        end else if (stallLeft == 0) begin
            // alternate busy and quiet windows of random length
            i_ioFull <= !i_ioFull;
            stallLeft = 1 + int'(rnd[2:0]);
        end else begin
            stallLeft = stallLeft - 1;
        end
    end

    // ack sanity around reset and against the req level
    always @(posedge clk) begin
        if (quietCycles != 0 && (o_dataAck !== 1'b0 || o_fetchAck !== 1'b0)) begin
            $display("[ERROR] %0t: ack high during or right after reset", $time);
            errCount++;
        end
        if (rst) begin
            quietCycles = 4;
        end else if (quietCycles != 0) begin
            quietCycles--;
        end
        if (!rst && o_dataAck === 1'b1 && dataAckPrev === 1'b0 && !i_dataReq) begin
            $display("[ERROR] %0t: data ack rose while data req was low", $time);
            errCount++;
        end
        if (!rst && o_fetchAck === 1'b1 && fetchAckPrev === 1'b0 && !i_fetchReq) begin
            $display("[ERROR] %0t: fetch ack rose while fetch req was low", $time);
            errCount++;
        end
        dataAckPrev  <= o_dataAck;
        fetchAckPrev <= o_fetchAck;
    end

    task automatic waitAck(input logic onData, input logic level, output logic ok);
        int   cycles;
        logic ack;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            ack = onData ? o_dataAck : o_fetchAck;
            if (ack === level) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            $display("Timeout at %0t: %s ack did not reach %0b within %0d cycles",
                     $time, onData ? "data" : "fetch", level, ACK_TIMEOUT);
            timeoutCount++;
        end
    endtask

    task automatic dataAccess(input logic write, input logic [LEN_W-1:0] len,
                              input logic [`MC_ADDR_W-1:0] addr,
                              input logic [`MC_DATA_W-1:0] wdata,
                              output logic [`MC_DATA_W-1:0] rdata, output logic ok);
        logic dropped;
        @(posedge clk);
        i_dataReq   <= 1'b1;
        i_dataWrite <= write;
        i_dataLen   <= len;
        i_dataAddr  <= addr;
        i_dataWdata <= wdata;
        waitAck(1'b1, 1'b1, ok);
        rdata = o_dataRdata;
        if (ok && firstAck == OP_STORE) begin
            firstAck = OP_LOAD;
        end
        // slow req fall now and then
        repeat (gapDraw) @(posedge clk);
        i_dataReq <= 1'b0;
        waitAck(1'b1, 1'b0, dropped);
        ok = ok && dropped;
    endtask

    task automatic fetchAccess(input logic [`MC_ADDR_W-1:0] addr,
                               output logic [`MC_DATA_W-1:0] inst, output logic ok);
        logic dropped;
        @(posedge clk);
        i_fetchReq  <= 1'b1;
        i_fetchAddr <= addr;
        waitAck(1'b0, 1'b1, ok);
        inst = o_fetchInst;
        if (ok && firstAck == OP_STORE) begin
            firstAck = OP_FETCH;
        end
        repeat (gapDraw) @(posedge clk);
        i_fetchReq <= 1'b0;
        waitAck(1'b0, 1'b0, dropped);
        ok = ok && dropped;
    endtask

    task automatic checkWord(input logic [`MC_DATA_W-1:0] got,
                             input logic [`MC_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s returned %h, expected %h", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic checkGrant(input memOp_e got, input memOp_e exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: first ack went to %s, expected %s",
                     $time, got.name(), exp.name());
            errCount++;
        end
    endtask

    task automatic runVector(input logic [8*16-1:0] op, input logic [`MC_ADDR_W-1:0] addr,
                             input logic [LEN_W-1:0] len, input logic [`MC_DATA_W-1:0] wdata,
                             input logic [`MC_DATA_W-1:0] exp);
        logic [`MC_DATA_W-1:0] dataRes;
        logic [`MC_DATA_W-1:0] fetchRes;
        logic                  dataOk;
        logic                  fetchOk;
        case (op)
            "S": dataAccess(1'b1, len, addr, wdata, dataRes, dataOk);
            "L": begin
                dataAccess(1'b0, len, addr, '0, dataRes, dataOk);
                if (dataOk) begin
                    checkWord(dataRes, exp, "load");
                end
            end
            "F": begin
                fetchAccess(addr, fetchRes, fetchOk);
                if (fetchOk) begin
                    checkWord(fetchRes, exp, "fetch");
                end
            end
            "B": begin
                // store marks that no ack has been seen yet
                firstAck = OP_STORE;
                fork
                    dataAccess(1'b0, len, addr, '0, dataRes, dataOk);
                    fetchAccess(addr, fetchRes, fetchOk);
                join
                if (dataOk && fetchOk) begin
                    checkGrant(firstAck, OP_LOAD);
                    checkWord(dataRes, exp, "paired load");
                    checkWord(fetchRes, exp, "paired fetch");
                end
            end
            "X": stallOn <= addr[0];
            default: begin
                $display("Unknown operation '%c' in the vector file", op[7:0]);
                fileErrCount++;
            end
        endcase
    endtask

    initial begin
        logic [8*16-1:0]       tok;
        logic [8*128-1:0]      restOfLine;
        logic [`MC_ADDR_W-1:0] vAddr;
        logic [LEN_W-1:0]      vLen;
        logic [`MC_DATA_W-1:0] vWdata;
        logic [`MC_DATA_W-1:0] vExp;
        int                    fd;
        int                    n;
        rst         = 1'b1;
        i_ioFull    = 1'b0;
        i_fetchReq  = 1'b0;
        i_fetchAddr = '0;
        i_dataReq   = 1'b0;
        i_dataWrite = 1'b0;
        i_dataLen   = '0;
        i_dataAddr  = '0;
        i_dataWdata = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        fd = $fopen("dv/memSubsys_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file dv/memSubsys_vectors.txt");
            fileErrCount++;
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tok);
                if (n != 1) begin
                    break;
                end
                if (tok == "#") begin
                    n = $fgets(restOfLine, fd);
                end else begin
                    n = $fscanf(fd, "%h %d %h %h", vAddr, vLen, vWdata, vExp);
                    if (n != 4) begin
                        $display("A vector line has fewer than five columns");
                        fileErrCount++;
                        break;
                    end
                    runVector(tok, vAddr, vLen, vWdata, vExp);
                end
            end
            $fclose(fd);
        end

        repeat (5) @(posedge clk);
        $display("errors: %0d mismatches, %0d timeouts, %0d vector file problems",
                 errCount, timeoutCount, fileErrCount);
        if (errCount + timeoutCount + fileErrCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/memSubsys.sv ====
`include "memctrl_config.svh"

module memSubsys (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_ioFull,

    // instruction fetch port
    input  logic                          i_fetchReq,
    input  logic [`MC_ADDR_W-1:0]         i_fetchAddr,
    output logic                          o_fetchAck,
    output logic [`MC_DATA_W-1:0]         o_fetchInst,

    // data load/store port
    input  logic                          i_dataReq,
    input  logic                          i_dataWrite,
    input  logic [memctrl_pkg::LEN_W-1:0] i_dataLen,
    input  logic [`MC_ADDR_W-1:0]         i_dataAddr,
    input  logic [`MC_DATA_W-1:0]         i_dataWdata,
    output logic                          o_dataAck,
    output logic [`MC_DATA_W-1:0]         o_dataRdata
);

    memReqIf reqBus ();
    ramIf    ramBus ();

    reqArbiter u_reqArbiter (
        .clk         (clk),
        .rst         (rst),
        .i_fetchReq  (i_fetchReq),
        .i_fetchAddr (i_fetchAddr),
        .i_dataReq   (i_dataReq),
        .i_dataWrite (i_dataWrite),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .o_fetchAck  (o_fetchAck),
        .o_fetchInst (o_fetchInst),
        .o_dataAck   (o_dataAck),
        .o_dataRdata (o_dataRdata),
        .seqPort     (reqBus.arb)
    );

    byteSequencer u_byteSequencer (
        .clk      (clk),
        .rst      (rst),
        .i_ioFull (i_ioFull),
        .reqPort  (reqBus.seq),
        .ramPort  (ramBus.seq)
    );

    byteRam u_byteRam (
        .clk     (clk),
        .ramPort (ramBus.ram)
    );

endmodule

// ==== rtl/byteRam.sv ====
`include "memctrl_config.svh"

module byteRam (
    input logic clk,
    ramIf.ram   ramPort
);
    logic [`MC_BYTE_W-1:0] mem [`MC_RAM_DEPTH];

    // write lands at the closing edge
    always_ff @(posedge clk) begin
        if (ramPort.we) begin
            mem[ramPort.addr] <= ramPort.wdata;
        end
    end

    // registered read, one cycle latency, old data on a same-address write
    always_ff @(posedge clk) begin
        ramPort.rdata <= mem[ramPort.addr];
    end

endmodule

// ==== rtl/byteSequencer.sv ====
`include "memctrl_config.svh"

module byteSequencer (
    input  logic clk,
    input  logic rst,
    input  logic i_ioFull,
    memReqIf.seq reqPort,
    ramIf.seq    ramPort
);
    import memctrl_pkg::*;

    seqState_e             state;
    memOp_e                opQ;
    logic [`MC_ADDR_W-1:0] baseAddr;
    logic [LEN_W-1:0]      lenQ;
    logic [LEN_W-1:0]      idx;
    logic [`MC_DATA_W-1:0] wdataQ;
    logic [`MC_DATA_W-1:0] rdAcc;
    logic                  rdPending;
    logic [1:0]            rdLane;
    logic                  accept;
    logic                  issue;
    logic                  lastByte;

    // start is taken even under stall since the arbiter pulses it only once
    assign accept   = (state == SEQ_IDLE) && reqPort.start;
    assign issue    = (state == SEQ_ISSUE) && !i_ioFull;
    assign lastByte = (idx == lenQ - LEN_W'(1));

    // RAM port
    assign ramPort.addr  = baseAddr + `MC_ADDR_W'(idx);
    assign ramPort.we    = issue && (opQ == OP_STORE);
    assign ramPort.wdata = wdataQ[idx[1:0]*`MC_BYTE_W +: `MC_BYTE_W];

    // result goes back in the done cycle
    assign reqPort.done  = (state == SEQ_DONE) && !i_ioFull;
    assign reqPort.rdata = rdAcc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SEQ_IDLE;
            idx       <= '0;
            rdPending <= 1'b0;
        end else begin
            // byte issued now comes back next cycle even if stalled then
            rdPending <= issue && (opQ != OP_STORE);
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        idx   <= '0;
                        state <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    if (issue) begin
                        idx <= idx + 1'b1;
                        if (lastByte) begin
                            if (opQ == OP_STORE) begin
                                state <= SEQ_DONE;
                            end else begin
                                state <= SEQ_DRAIN;
                            end
                        end
                    end
                end
                SEQ_DRAIN: begin
                    // last byte lands in rdAcc at this edge
                    if (!i_ioFull) begin
                        state <= SEQ_DONE;
                    end
                end
                SEQ_DONE: begin
                    if (!i_ioFull) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // access fields and read assembly
    always_ff @(posedge clk) begin
        if (accept) begin
            opQ      <= reqPort.op;
            baseAddr <= reqPort.addr;
            wdataQ   <= reqPort.wdata;
            if (reqPort.op == OP_FETCH) begin
                lenQ <= LEN_W'(4);
            end else begin
                lenQ <= reqPort.len;
            end
            // unused upper lanes stay zero
            rdAcc <= '0;
        end else if (rdPending) begin
            rdAcc[rdLane*`MC_BYTE_W +: `MC_BYTE_W] <= ramPort.rdata;
        end
        if (issue) begin
            rdLane <= idx[1:0];
        end
    end

    // a fetch or load never writes the RAM before its done
    a_weOnlyOnStore: assert property (@(posedge clk) disable iff (rst)
        (accept && reqPort.op != OP_STORE) |=> !ramPort.we throughout (reqPort.done [->1]));

    a_legalLen: assert property (@(posedge clk) disable iff (rst)
        reqPort.start |-> reqPort.len inside {LEN_W'(1), LEN_W'(2), LEN_W'(4)});

    // arbiter never grants while an access is still in flight here
    a_startWhenIdle: assert property (@(posedge clk) disable iff (rst)
        reqPort.start |-> (state == SEQ_IDLE));

endmodule

// ==== rtl/reqArbiter.sv ====
`include "memctrl_config.svh"

module reqArbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_fetchReq,
    input  logic [`MC_ADDR_W-1:0]         i_fetchAddr,
    input  logic                          i_dataReq,
    input  logic                          i_dataWrite,
    input  logic [memctrl_pkg::LEN_W-1:0] i_dataLen,
    input  logic [`MC_ADDR_W-1:0]         i_dataAddr,
    input  logic [`MC_DATA_W-1:0]         i_dataWdata,
    output logic                          o_fetchAck,
    output logic [`MC_DATA_W-1:0]         o_fetchInst,
    output logic                          o_dataAck,
    output logic [`MC_DATA_W-1:0]         o_dataRdata,
    memReqIf.arb                          seqPort
);
    import memctrl_pkg::*;

    arbState_e state;
    logic      fetchReqQ;
    logic      dataReqQ;
    // set while the data port owns the current access
    logic      grantData;

    // data port wins when both are waiting
    always_comb begin
        seqPort.start = (state == ARB_IDLE) && (dataReqQ || fetchReqQ);
        seqPort.wdata = i_dataWdata;
        if (dataReqQ) begin
            seqPort.addr = i_dataAddr;
            seqPort.len  = i_dataLen;
            if (i_dataWrite) begin
                seqPort.op = OP_STORE;
            end else begin
                seqPort.op = OP_LOAD;
            end
        end else begin
            seqPort.addr = i_fetchAddr;
            seqPort.len  = LEN_W'(4);
            seqPort.op   = OP_FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ARB_IDLE;
            fetchReqQ   <= 1'b0;
            dataReqQ    <= 1'b0;
            grantData   <= 1'b0;
            o_fetchAck  <= 1'b0;
            o_dataAck   <= 1'b0;
            o_fetchInst <= '0;
            o_dataRdata <= '0;
        end else begin
            fetchReqQ <= i_fetchReq;
            dataReqQ  <= i_dataReq;
            case (state)
                ARB_IDLE: begin
                    if (seqPort.start) begin
                        grantData <= dataReqQ;
                        state     <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (seqPort.done) begin
                        if (grantData) begin
                            o_dataRdata <= seqPort.rdata;
                            o_dataAck   <= 1'b1;
                        end else begin
                            o_fetchInst <= seqPort.rdata;
                            o_fetchAck  <= 1'b1;
                        end
                        state <= ARB_ACK;
                    end
                end
                ARB_ACK: begin
                    // result stays put until the served port drops req
                    if (grantData ? !dataReqQ : !fetchReqQ) begin
                        o_dataAck  <= 1'b0;
                        o_fetchAck <= 1'b0;
                        state      <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // no second grant before the sequencer reports done
    a_startFromIdle: assert property (@(posedge clk) disable iff (rst)
        seqPort.start |=> !seqPort.start throughout (seqPort.done [->1]));

    a_oneAck: assert property (@(posedge clk) disable iff (rst)
        !(o_fetchAck && o_dataAck));

endmodule

// ==== rtl/memReqIf.sv ====
`include "memctrl_config.svh"

// one granted access going down, its result coming back
interface memReqIf;
    import memctrl_pkg::*;

    logic                  start;
    memOp_e                op;
    logic [`MC_ADDR_W-1:0] addr;
    logic [LEN_W-1:0]      len;
    logic [`MC_DATA_W-1:0] wdata;
    logic                  done;
    logic [`MC_DATA_W-1:0] rdata;

    modport arb (
        output start, op, addr, len, wdata,
        input  done, rdata
    );

    modport seq (
        input  start, op, addr, len, wdata,
        output done, rdata
    );
endinterface

// byte-wide RAM port, registered read
interface ramIf;
    logic                  we;
    logic [`MC_ADDR_W-1:0] addr;
    logic [`MC_BYTE_W-1:0] wdata;
    logic [`MC_BYTE_W-1:0] rdata;

    modport seq (
        output we, addr, wdata,
        input  rdata
    );

    modport ram (
        input  we, addr, wdata,
        output rdata
    );
endinterface

// ==== rtl/memctrl_pkg.sv ====
package memctrl_pkg;

    // access length in bytes, legal values 1, 2 and 4
    localparam int LEN_W = 3;

    typedef enum logic [1:0] {
        OP_FETCH = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } memOp_e;

    // byte sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ISSUE = 2'd1,
        SEQ_DRAIN = 2'd2,
        SEQ_DONE  = 2'd3
    } seqState_e;

    // request arbiter
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_BUSY = 2'd1,
        ARB_ACK  = 2'd2
    } arbState_e;

endpackage

// ==== rtl/memctrl_config.svh ====
`ifndef MEMCTRL_CONFIG_SVH
`define MEMCTRL_CONFIG_SVH

// byte address width, 128 KiB of main memory
`define MC_ADDR_W 17

// word width seen by both requesters
`define MC_DATA_W 32

// one RAM cycle moves a single byte
`define MC_BYTE_W 8

// one RAM entry per byte address
`define MC_RAM_DEPTH (1 << `MC_ADDR_W)

`endif
